// ==== hw/flash_consts.svh ====
`ifndef FLASH_CONSTS_SVH
`define FLASH_CONSTS_SVH

// bus phases one chip access step is held
// 4 phases at 40 MHz cover the 75 ns read and 60 ns write times
`define FLASH_WAIT_PHASES 4

`define FLASH_WORD_W  32
`define FLASH_HWORD_W 16

// chip byte address, 8 MB part
`define FLASH_ADDR_W 23

// flash window in bus word address space, top bits only
`define FLASH_WIN_W    10
`define FLASH_WIN_BASE 10'h1E0

`define HIGHZ_HWORD 16'hzzzz

`endif

// ==== hw/flash_pkg.sv ====
`include "flash_consts.svh"

package flash_pkg;

    typedef logic [`FLASH_WORD_W-1:0]  word_t;
    typedef logic [`FLASH_HWORD_W-1:0] half_word_t;
    typedef logic [`FLASH_WORD_W-1:0]  bus_addr_t;   // word address
    typedef logic [`FLASH_ADDR_W-1:0]  flash_addr_t; // byte address, bit 0 unused

    // one wait state per bus phase of a chip access
    typedef enum logic [3:0] {
        st_reset,
        st_idle,
        st_wr_0,
        st_wr_1,
        st_wr_2,
        st_wr_3,
        st_rd_lo_0,
        st_rd_lo_1,
        st_rd_lo_2,
        st_rd_lo_3,
        st_rd_hi_0,
        st_rd_hi_1,
        st_rd_hi_2,
        st_rd_hi_3
    } flash_state_t;

    typedef enum logic [`FLASH_HWORD_W-1:0] {
        cmd_read_array = 16'h00FF
    } flash_cmd_t;

endpackage

// ==== hw/flash_bus_port.sv ====
`include "flash_consts.svh"

module flash_bus_port (
    input  logic                clk,
    input  logic                rst,
    input  logic                bus_read,
    input  logic                bus_write,
    input  flash_pkg::bus_addr_t bus_address,
    input  logic [3:0]          bus_mask,
    input  flash_pkg::word_t    bus_data_wr,
    output flash_pkg::word_t    bus_data_rd,
    output logic                bus_stall,
    output logic                bus_error,
    output logic                req_read,
    output logic                req_write,
    output flash_pkg::bus_addr_t req_address,
    output logic [3:0]          req_mask,
    output flash_pkg::word_t    req_data,
    output logic                bus_phase,
    input  logic                busy,
    input  flash_pkg::word_t    rd_data
);

    logic in_window;
    logic held;
    logic strobe;
    logic busy_q;
    logic busy_fall;

    assign in_window = bus_address[`FLASH_WORD_W-1 -: `FLASH_WIN_W] == `FLASH_WIN_BASE;
    assign strobe    = bus_read | bus_write;
    assign held      = req_read | req_write;
    assign busy_fall = busy_q & ~busy; // controller finished our access

    // the master sees the stall one cycle after its strobe
    assign bus_stall = held;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus_phase <= 1'b0;
            busy_q    <= 1'b0;
            req_read  <= 1'b0;
            req_write <= 1'b0;
            bus_error <= 1'b0;
        end else begin
            bus_phase <= ~bus_phase; // low half is the falling phase of the bus clock
            busy_q    <= busy;
            bus_error <= 1'b0;

            if (held) begin
                if (busy_fall) begin
                    req_read  <= 1'b0;
                    req_write <= 1'b0;
                end
            end else if (strobe) begin
                if (in_window) begin
                    req_read  <= bus_read;
                    req_write <= ~bus_read & bus_write; // read wins if both strobe
                end else begin
                    bus_error <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!held && strobe) begin
            req_address <= bus_address;
            req_mask    <= bus_mask;
            req_data    <= bus_data_wr;
        end

        // valid from the cycle the stall drops
        if (req_read && busy_fall) begin
            bus_data_rd <= rd_data;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(req_read && req_write));

    // controller only starts an access on a request that is still held here
    assert property (@(posedge clk) disable iff (rst) $rose(busy) |-> held);

endmodule

// ==== hw/flash_controller.sv ====
`include "flash_consts.svh"

module flash_controller (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  bus_phase,
    input  logic                  req_read,
    input  logic                  req_write,
    input  flash_pkg::bus_addr_t  req_address,
    input  logic [3:0]            req_mask,
    input  flash_pkg::word_t      req_data,
    output logic                  busy,
    output flash_pkg::word_t      rd_data,
    output flash_pkg::flash_addr_t flash_address,
    inout  wire flash_pkg::half_word_t flash_data,
    output logic                  flash_ce_n,
    output logic                  flash_oe_n,
    output logic                  flash_we_n
);

    import flash_pkg::*;

    flash_state_t state;
    half_word_t   data_to_write;
    logic         drive_data;
    logic         step;
    logic         write_upper;
    flash_addr_t  lo_addr;
    flash_addr_t  hi_addr;

    assign step = ~bus_phase; // advance on the falling phase only

    // word address to chip byte address
    assign lo_addr = {req_address[`FLASH_ADDR_W-3:0], 2'b00};
    assign hi_addr = {req_address[`FLASH_ADDR_W-3:0], 2'b10};

    // 16-bit writes only, upper half when the low mask bits are clear
    assign write_upper = ~|req_mask[1:0];

    assign flash_data = drive_data ? data_to_write : `HIGHZ_HWORD;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= st_reset;
            busy       <= 1'b0;
            drive_data <= 1'b0;
            flash_ce_n <= 1'b1;
            flash_oe_n <= 1'b1;
            flash_we_n <= 1'b1;
        end else if (step) begin
            case (state)
                st_reset: begin
                    // one read-array command puts the chip in read mode
                    flash_ce_n <= 1'b0;
                    flash_we_n <= 1'b0;
                    flash_oe_n <= 1'b1;
                    drive_data <= 1'b1;
                    state      <= st_wr_0;
                end

                st_idle: begin
                    flash_ce_n <= 1'b1;
                    flash_oe_n <= 1'b1;
                    flash_we_n <= 1'b1;
                    drive_data <= 1'b0; // release data after the write hold
                    if (req_read) begin
                        busy       <= 1'b1;
                        flash_ce_n <= 1'b0;
                        flash_oe_n <= 1'b0;
                        state      <= st_rd_lo_0;
                    end else if (req_write) begin
                        busy       <= 1'b1;
                        flash_ce_n <= 1'b0;
                        flash_we_n <= 1'b0;
                        drive_data <= 1'b1;
                        state      <= st_wr_0;
                    end
                end

                st_wr_0: state <= st_wr_1;
                st_wr_1: state <= st_wr_2;
                st_wr_2: state <= st_wr_3;

                st_wr_3: begin
                    // we_n rises here, data stays driven one more step
                    flash_ce_n <= 1'b1;
                    flash_we_n <= 1'b1;
                    flash_oe_n <= 1'b1;
                    busy       <= 1'b0;
                    state      <= st_idle;
                end

                st_rd_lo_0: state <= st_rd_lo_1;
                st_rd_lo_1: state <= st_rd_lo_2;
                st_rd_lo_2: state <= st_rd_lo_3;
                st_rd_lo_3: state <= st_rd_hi_0; // oe_n stays low across both halves

                st_rd_hi_0: state <= st_rd_hi_1;
                st_rd_hi_1: state <= st_rd_hi_2;
                st_rd_hi_2: state <= st_rd_hi_3;

                st_rd_hi_3: begin
                    flash_ce_n <= 1'b1;
                    flash_oe_n <= 1'b1;
                    flash_we_n <= 1'b1;
                    busy       <= 1'b0;
                    state      <= st_idle;
                end

                default: begin
                    flash_ce_n <= 1'b1;
                    flash_oe_n <= 1'b1;
                    flash_we_n <= 1'b1;
                    drive_data <= 1'b0;
                    busy       <= 1'b0;
                    state      <= st_idle;
                end
            endcase
        end
    end

    // address, write data and read capture
    always_ff @(posedge clk) begin
        if (step) begin
            case (state)
                st_reset: begin
                    flash_address <= '0;
                    data_to_write <= half_word_t'(cmd_read_array);
                end

                st_idle: begin
                    if (req_read) begin
                        flash_address <= lo_addr;
                    end else if (req_write) begin
                        flash_address <= write_upper ? hi_addr : lo_addr;
                        data_to_write <= write_upper ? req_data[31:16] : req_data[15:0];
                    end
                end

                st_rd_lo_3: begin
                    rd_data[15:0] <= flash_data;
                    flash_address <= hi_addr;
                end

                st_rd_hi_3: rd_data[31:16] <= flash_data;

                default: ;
            endcase
        end
    end

    // the chip owns the data pins whenever its outputs are enabled
    assert property (@(posedge clk) disable iff (rst) !(drive_data && !flash_oe_n));

    assert property (@(posedge clk) disable iff (rst)
        (state == st_idle && !busy) |-> flash_ce_n);

    // write pulse lasts the full wait count, two clk per step
    assert property (@(posedge clk) disable iff (rst)
        $fell(flash_we_n) |-> !flash_we_n [*(2 * `FLASH_WAIT_PHASES)] ##1 flash_we_n);

endmodule

// ==== hw/flash_subsystem.sv ====
module flash_subsystem (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   bus_read,
    input  logic                   bus_write,
    input  flash_pkg::bus_addr_t   bus_address,
    input  logic [3:0]             bus_mask,
    input  flash_pkg::word_t       bus_data_wr,
    output flash_pkg::word_t       bus_data_rd,
    output logic                   bus_stall,
    output logic                   bus_error,
    output flash_pkg::flash_addr_t flash_address,
    inout  wire flash_pkg::half_word_t flash_data,
    output logic                   flash_ce_n,
    output logic                   flash_oe_n,
    output logic                   flash_we_n,
    output logic                   flash_vpen,
    output logic                   flash_byte_n,
    output logic                   flash_rp_n
);

    import flash_pkg::*;

    logic       req_read;
    logic       req_write;
    bus_addr_t  req_address;
    logic [3:0] req_mask;
    word_t      req_data;
    logic       bus_phase;
    logic       busy;
    word_t      rd_data;

    assign flash_vpen   = 1'b0; // block erase/program protection stays on
    assign flash_byte_n = 1'b1; // 16-bit mode
    assign flash_rp_n   = 1'b1;

    flash_bus_port u_port (
        .clk         (clk),
        .rst         (rst),
        .bus_read    (bus_read),
        .bus_write   (bus_write),
        .bus_address (bus_address),
        .bus_mask    (bus_mask),
        .bus_data_wr (bus_data_wr),
        .bus_data_rd (bus_data_rd),
        .bus_stall   (bus_stall),
        .bus_error   (bus_error),
        .req_read    (req_read),
        .req_write   (req_write),
        .req_address (req_address),
        .req_mask    (req_mask),
        .req_data    (req_data),
        .bus_phase   (bus_phase),
        .busy        (busy),
        .rd_data     (rd_data)
    );

    flash_controller u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .bus_phase     (bus_phase),
        .req_read      (req_read),
        .req_write     (req_write),
        .req_address   (req_address),
        .req_mask      (req_mask),
        .req_data      (req_data),
        .busy          (busy),
        .rd_data       (rd_data),
        .flash_address (flash_address),
        .flash_data    (flash_data),
        .flash_ce_n    (flash_ce_n),
        .flash_oe_n    (flash_oe_n),
        .flash_we_n    (flash_we_n)
    );

endmodule

// ==== verif/flash_chip_model.sv ====
`include "flash_consts.svh"

module flash_chip_model (
    input  logic [`FLASH_ADDR_W-1:0]  flash_address,
    inout  wire  [`FLASH_HWORD_W-1:0] flash_data,
    input  logic                      flash_ce_n,
    input  logic                      flash_oe_n,
    input  logic                      flash_we_n
);

    localparam int MEM_DEPTH = 65536; // low 128 KB of the part
    localparam int OE_DELAY  = 6;     // output enable to data valid

    logic [`FLASH_HWORD_W-1:0] mem [0:MEM_DEPTH-1];
    logic [`FLASH_HWORD_W-1:0] rd_value;
    logic                      out_en;
    logic                      wr_active;

    // preload, half-word address xor a5a5
    initial begin
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] = 16'(i) ^ 16'hA5A5;
        end
    end

    assign rd_value = mem[flash_address[16:1]];

    // data appears a little after ce_n and oe_n are both low
    assign #OE_DELAY out_en = !flash_ce_n && !flash_oe_n;
    assign flash_data = out_en ? rd_value : `HIGHZ_HWORD;

    assign wr_active = !flash_ce_n && !flash_we_n;

    // write ends on whichever of ce_n and we_n rises first
    always @(negedge wr_active) begin
        if (!$isunknown(flash_address)) begin
            mem[flash_address[16:1]] = flash_data;
        end
    end

endmodule

// ==== verif/flash_subsystem_tb.sv ====
`include "flash_consts.svh"

module flash_subsystem_tb;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 16;
    localparam int N_RANDOM      = 16;
    localparam int N_ACCESSES    = 8 + 2 * N_RANDOM;
    localparam int WATCHDOG_TIME = (N_ACCESSES * 40 + RESET_CYCLES) * CLK_PERIOD;
    localparam logic [15:0] CMD_READ_ARRAY = 16'h00FF;

    logic        clk;
    logic        rst;
    logic        bus_read;
    logic        bus_write;
    logic [31:0] bus_address;
    logic [3:0]  bus_mask;
    logic [31:0] bus_data_wr;
    logic [31:0] bus_data_rd;
    logic        bus_stall;
    logic        bus_error;
    logic [`FLASH_ADDR_W-1:0] flash_address;
    wire  [15:0] flash_data;
    logic        flash_ce_n;
    logic        flash_oe_n;
    logic        flash_we_n;
    logic        flash_vpen;
    logic        flash_byte_n;
    logic        flash_rp_n;

    string       test_name;
    logic        chk_cmd;
    logic        chk_win;
    logic        rd_pending;
    logic        wr_pending;
    logic [31:0] exp_rd;
    logic [15:0] tgt_idx;       // half-word index of the last write
    logic [15:0] exp_tgt;
    logic [15:0] exp_pair;
    logic [15:0] mem_tgt;
    logic [15:0] mem_pair;
    logic [15:0] mem_word0;
    logic        addr_in_win;

    logic [15:0] shadow [0:65535];
    logic [14:0] rnd_addr [0:N_RANDOM-1];
    logic [31:0] lfsr_state;
    int          fail_count;
    int          pass_tests;
    int          failed_tests;

    flash_subsystem dut0 (
        .clk           (clk),
        .rst           (rst),
        .bus_read      (bus_read),
        .bus_write     (bus_write),
        .bus_address   (bus_address),
        .bus_mask      (bus_mask),
        .bus_data_wr   (bus_data_wr),
        .bus_data_rd   (bus_data_rd),
        .bus_stall     (bus_stall),
        .bus_error     (bus_error),
        .flash_address (flash_address),
        .flash_data    (flash_data),
        .flash_ce_n    (flash_ce_n),
        .flash_oe_n    (flash_oe_n),
        .flash_we_n    (flash_we_n),
        .flash_vpen    (flash_vpen),
        .flash_byte_n  (flash_byte_n),
        .flash_rp_n    (flash_rp_n)
    );

    flash_chip_model chip0 (
        .flash_address (flash_address),
        .flash_data    (flash_data),
        .flash_ce_n    (flash_ce_n),
        .flash_oe_n    (flash_oe_n),
        .flash_we_n    (flash_we_n)
    );

    assign addr_in_win = bus_address[31 -: `FLASH_WIN_W] == `FLASH_WIN_BASE;
    assign mem_tgt     = chip0.mem[tgt_idx];
    assign mem_pair    = chip0.mem[tgt_idx ^ 16'h0001];
    assign mem_word0   = chip0.mem[0];

    always #(CLK_PERIOD / 2) clk = ~clk;

    assert property (@(negedge clk) rst |-> flash_ce_n && flash_oe_n && flash_we_n)
        else begin
            fail_count++;
            $display("error in %s: chip strobes active while reset is held", test_name);
        end

    assert property (@(posedge clk) chk_cmd |-> mem_word0 == CMD_READ_ARRAY)
        else begin
            fail_count++;
            $display("[FAIL] %s expected %h actual %h", test_name, CMD_READ_ARRAY,
                     $sampled(mem_word0));
        end

    // bus_data_rd is valid once the stall has dropped
    assert property (@(posedge clk) disable iff (rst)
        rd_pending && $fell(bus_stall) |-> bus_data_rd == exp_rd)
        else begin
            fail_count++;
            $display("[FAIL] %s expected %h actual %h", test_name, exp_rd,
                     $sampled(bus_data_rd));
        end

    assert property (@(posedge clk) disable iff (rst)
        wr_pending && $fell(bus_stall) |-> mem_tgt == exp_tgt)
        else begin
            fail_count++;
            $display("[FAIL] %s expected %h actual %h", test_name, exp_tgt,
                     $sampled(mem_tgt));
        end

    assert property (@(posedge clk) disable iff (rst)
        wr_pending && $fell(bus_stall) |-> mem_pair == exp_pair)
        else begin
            fail_count++;
            $display("[FAIL] %s expected %h actual %h", test_name, exp_pair,
                     $sampled(mem_pair));
        end

    assert property (@(posedge clk) disable iff (rst)
        (bus_read || bus_write) && addr_in_win && !bus_stall |=> bus_stall)
        else begin
            fail_count++;
            $display("error in %s: accepted strobe did not raise bus_stall", test_name);
        end

    assert property (@(posedge clk) disable iff (rst)
        (bus_read || bus_write) && addr_in_win |=> !bus_error)
        else begin
            fail_count++;
            $display("error in %s: bus_error for an address inside the window", test_name);
        end

    assert property (@(posedge clk) disable iff (rst)
        chk_win && (bus_read || bus_write) |=> bus_error ##1 !bus_error)
        else begin
            fail_count++;
            $display("error in %s: no single-cycle bus_error for outside address",
                     test_name);
        end

    assert property (@(posedge clk) disable iff (rst) chk_win |-> !bus_stall && flash_ce_n)
        else begin
            fail_count++;
            $display("error in %s: outside access stalled the bus or enabled the chip",
                     test_name);
        end

    assert property (@(posedge clk) !flash_vpen && flash_byte_n && flash_rp_n)
        else begin
            fail_count++;
            $display("error in %s: constant chip pins at the wrong level", test_name);
        end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] win_addr(input logic [14:0] word);
        return {`FLASH_WIN_BASE, 7'd0, word};
    endfunction

    task automatic bus_cycle(input logic is_read, input logic [14:0] word,
                             input logic [3:0] mask, input logic [31:0] data);
        @(posedge clk);
        #2;
        bus_read    = is_read;
        bus_write   = !is_read;
        bus_address = win_addr(word);
        bus_mask    = mask;
        bus_data_wr = data;
        @(posedge clk);
        #2;
        bus_read  = 1'b0;
        bus_write = 1'b0;
        while (bus_stall) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk); // checkers sample the stall edge here
        #2;
        rd_pending = 1'b0;
        wr_pending = 1'b0;
    endtask

    task automatic read_word(input logic [14:0] word);
        exp_rd     = {shadow[{word, 1'b1}], shadow[{word, 1'b0}]};
        rd_pending = 1'b1;
        bus_cycle(1'b1, word, 4'b1111, 32'd0);
    endtask

    task automatic write_half(input logic [14:0] word, input logic upper,
                              input logic [31:0] data);
        logic [15:0] lo_idx;
        lo_idx = {word, 1'b0};
        if (upper) begin
            tgt_idx = lo_idx | 16'h0001;
            shadow[tgt_idx] = data[31:16];
        end else begin
            tgt_idx = lo_idx;
            shadow[tgt_idx] = data[15:0];
        end
        exp_tgt    = shadow[tgt_idx];
        exp_pair   = shadow[tgt_idx ^ 16'h0001];
        wr_pending = 1'b1;
        bus_cycle(1'b0, word, upper ? 4'b1100 : 4'b0011, data);
    endtask

    task automatic outside_access(input logic is_read, input logic [31:0] addr);
        @(posedge clk);
        #2;
        chk_win     = 1'b1;
        bus_read    = is_read;
        bus_write   = !is_read;
        bus_address = addr;
        @(posedge clk);
        #2;
        bus_read  = 1'b0;
        bus_write = 1'b0;
        repeat (3) @(posedge clk); // error pulse and the low cycle after it
        #2;
        chk_win = 1'b0;
    endtask

    task automatic random_traffic();
        logic [31:0] v;
        logic [31:0] data;
        logic        upper;
        for (int i = 0; i < N_RANDOM; i++) begin
            take_bits(15, v);
            rnd_addr[i] = v[14:0];
            take_bits(1, v);
            upper = v[0];
            take_bits(32, data);
            write_half(rnd_addr[i], upper, data);
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            read_word(rnd_addr[i]);
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        if (fail_count == fails_before) begin
            pass_tests++;
            $display("test %s: pass", name);
        end else begin
            failed_tests++;
            $display("test %s: FAIL, %0d checks", name, fail_count - fails_before);
        end
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired after %0d time units, accesses did not finish",
                 WATCHDOG_TIME);
        $display("Test failures found");
        $finish;
    end

    initial begin
        int fails_before;
        clk          = 1'b0;
        rst          = 1'b1;
        bus_read     = 1'b0;
        bus_write    = 1'b0;
        bus_address  = '0;
        bus_mask     = '0;
        bus_data_wr  = '0;
        chk_cmd      = 1'b0;
        chk_win      = 1'b0;
        rd_pending   = 1'b0;
        wr_pending   = 1'b0;
        exp_rd       = '0;
        tgt_idx      = '0;
        exp_tgt      = '0;
        exp_pair     = '0;
        fail_count   = 0;
        pass_tests   = 0;
        failed_tests = 0;
        lfsr_state   = 32'hc7a48568;
        test_name    = "reset";
        for (int i = 0; i < 65536; i++) begin
            shadow[i] = 16'(i) ^ 16'hA5A5;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        test_name    = "reset_cmd";
        fails_before = fail_count;
        @(posedge flash_we_n); // read-array command done
        @(posedge clk);
        #2;
        chk_cmd   = 1'b1;
        shadow[0] = CMD_READ_ARRAY;
        @(posedge clk);
        #2;
        chk_cmd = 1'b0;
        read_word(15'd0);
        report_test(test_name, fails_before);

        test_name    = "lower_write";
        fails_before = fail_count;
        write_half(15'h0123, 1'b0, 32'hDEAD_BEEF);
        report_test(test_name, fails_before);

        test_name    = "upper_write";
        fails_before = fail_count;
        write_half(15'h0123, 1'b1, 32'h1234_5678);
        report_test(test_name, fails_before);

        test_name    = "read";
        fails_before = fail_count;
        read_word(15'h0123);
        read_word(15'h0456); // preload only
        report_test(test_name, fails_before);

        test_name    = "window";
        fails_before = fail_count;
        outside_access(1'b1, {10'h1DF, 22'h000010});
        outside_access(1'b0, 32'h0000_0100);
        report_test(test_name, fails_before);

        test_name    = "random";
        fails_before = fail_count;
        random_traffic();
        report_test(test_name, fails_before);

        $display("%0d tests run, %0d passed, %0d failed, %0d failing checks",
                 pass_tests + failed_tests, pass_tests, failed_tests, fail_count);
        if (fail_count == 0 && failed_tests == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+hw
hw/flash_pkg.sv
hw/flash_bus_port.sv
hw/flash_controller.sv
hw/flash_subsystem.sv
verif/flash_chip_model.sv
verif/flash_subsystem_tb.sv
